// File: sms_pkg.sv
package sms_pkg;

	// ==============================
	// Download indices
	// ==============================
	localparam logic [7:0] IDX_SMS     = 8'd1;    // Master System cartridge
	localparam logic [7:0] IDX_GG      = 8'd2;    // Game Gear cartridge
	localparam logic [7:0] IDX_SYSMODE = 8'd4;
	localparam logic [7:0] IDX_DSW     = 8'd254;
	localparam logic [7:0] IDX_CODE    = 8'd255;  // Cheat records

	// Copier header in front of some images
	localparam int HEADER_BYTES = 512;

	// ==============================
	// Clock enable sequencer
	// ==============================
	localparam int CE_PERIOD    = 30;  // clk_sys cycles per sequence
	localparam int CE_VDP_STEP  = 5;
	localparam int CE_PIX_STEP  = 10;
	localparam int CE_CPU_STEP  = 15;
	localparam int CE_CPU_PHASE = 9;   // CPU slot within its step

	// ==============================
	// Types
	// ==============================
	typedef logic [24:0] ioctl_addr_t;  // Host byte address
	typedef logic [23:0] rom_waddr_t;   // External memory write address
	typedef logic [21:0] rom_addr_t;    // ROM read address
	typedef logic [7:0]  byte_t;
	typedef logic [4:0]  ce_cnt_t;

	// One cheat code, flags in the top word
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

endpackage

// File: dl_if.sv
`timescale 1ns/1ps

interface dl_if (
	input logic clk_sys,
	input logic reset
);
	import sms_pkg::*;

	// Host download bus
	logic        download;
	logic        wr;
	ioctl_addr_t addr;
	byte_t       dout;
	byte_t       index;

	logic cart_sel;    // Cartridge image bytes
	logic code_sel;    // Cheat record bytes
	logic download_q;  // Download level, one cycle late

	assign code_sel = download && (index == IDX_CODE);
	assign cart_sel = download && (index != IDX_CODE) &&
		(index != IDX_SYSMODE) && (index != IDX_DSW);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			download_q <= 1'b0;
		end else begin
			download_q <= download;
		end
	end

	modport host (output download, wr, addr, dout, index);
	modport sink (input download, wr, addr, dout, index, cart_sel, code_sel, download_q);

endinterface

// File: ce_gen.sv
`timescale 1ns/1ps

module ce_gen (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);
	import sms_pkg::*;

	ce_cnt_t cnt;
	ce_cnt_t cnt_inc;

	assign cnt_inc = cnt + 1'b1;

	// ==============================
	// Phase sequencer
	// ==============================
	// VDP every 5, pixel every 10, CPU at counts 9 and 24
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cnt    <= '0;
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			if (cnt == ce_cnt_t'(CE_PERIOD - 1)) begin
				cnt <= '0;
			end else begin
				cnt <= cnt_inc;
			end

			ce_vdp <= (int'(cnt_inc) % CE_VDP_STEP) == 0;
			ce_pix <= (int'(cnt_inc) % CE_PIX_STEP) == 0;
			ce_cpu <= (int'(cnt) % CE_CPU_STEP) == CE_CPU_PHASE;  // Phase kept for HCounter
			ce_sp  <= cnt[0];  // Half-rate sound enable
		end
	end

	// Pixel slots must line up with VDP slots
	pix_on_vdp: assert property (
		@(posedge clk_sys) disable iff (reset) ce_pix |-> ce_vdp
	) else $error("ce_gen: ce_pix without ce_vdp");

endmodule

// File: cart_loader.sv
`timescale 1ns/1ps

module cart_loader (
	input  logic                clk_sys,
	input  logic                reset,
	dl_if.sink                  dl,
	input  logic                rom_ack,
	output logic                rom_req,
	output sms_pkg::rom_waddr_t rom_waddr,
	output logic                ioctl_wait
);

	logic cart_start;  // First cycle of a cart download
	logic cart_wr;
	logic acked;       // Memory caught up with the request

	assign cart_start = dl.cart_sel & ~dl.download_q;
	assign cart_wr    = dl.wr & dl.cart_sel;
	assign acked      = (rom_req == rom_ack);

	// ==============================
	// Toggle request / acknowledge
	// ==============================
	// Each byte flips rom_req, memory answers by flipping rom_ack.
	// The write address only moves on once the byte is accepted.
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_wait <= 1'b0;
			rom_req    <= 1'b0;
			rom_waddr  <= '0;
		end else begin
			if (cart_wr) begin
				ioctl_wait <= 1'b1;      // Hold host off
				rom_req    <= ~rom_req;
			end else if (ioctl_wait && acked) begin
				ioctl_wait <= 1'b0;
				rom_waddr  <= rom_waddr + 1'b1;
			end

			// New image starts at the bottom of memory
			if (cart_start) begin
				rom_waddr <= '0;
			end
		end
	end

	// Host has to respect the wait level
	no_wr_in_wait: assert property (
		@(posedge clk_sys) disable iff (reset) ioctl_wait |-> !dl.wr
	) else $error("cart_loader: host write while ioctl_wait is high");

endmodule

// File: cart_mapper.sv
`timescale 1ns/1ps

module cart_mapper (
	input  logic               clk_sys,
	input  logic               reset,
	dl_if.sink                 dl,
	input  sms_pkg::rom_addr_t core_rom_addr,
	output sms_pkg::rom_addr_t rom_raddr,
	output logic               gg_mode
);
	import sms_pkg::*;

	rom_addr_t img_mask;     // OR of all written addresses
	rom_addr_t hdr_mask;     // Same, header stripped
	logic      hdr_flag;     // Image carries a copier header
	logic      cart_active;  // Cart download in progress
	logic      cart_wr;
	logic      cart_end;
	rom_addr_t wr_addr;
	rom_addr_t hdr_addr;

	assign cart_wr  = dl.wr & dl.cart_sel;
	assign cart_end = cart_active & dl.download_q & ~dl.download;
	assign wr_addr  = dl.addr[$bits(rom_addr_t)-1:0];
	assign hdr_addr = wr_addr - rom_addr_t'(HEADER_BYTES);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			img_mask    <= '0;
			hdr_mask    <= '0;
			hdr_flag    <= 1'b0;
			gg_mode     <= 1'b0;
			cart_active <= 1'b0;
		end else begin
			if (dl.cart_sel && !dl.download_q) begin
				cart_active <= 1'b1;
			end else if (cart_end) begin
				cart_active <= 1'b0;
			end

			if (cart_wr) begin
				img_mask <= (dl.addr == '0) ? '0 : (img_mask | wr_addr);
				hdr_mask <= (dl.addr == ioctl_addr_t'(HEADER_BYTES)) ?
					'0 : (hdr_mask | hdr_addr);
				gg_mode  <= (dl.index == IDX_GG);
			end

			// Address at the end equals image size
			if (cart_end) begin
				hdr_flag <= dl.addr[$clog2(HEADER_BYTES)];
			end
		end
	end

	// Core read address, skipping the header when present
	always_ff @(posedge clk_sys) begin
		if (hdr_flag) begin
			rom_raddr <= (core_rom_addr + rom_addr_t'(HEADER_BYTES)) & hdr_mask;
		end else begin
			rom_raddr <= core_rom_addr & img_mask;
		end
	end

endmodule

// File: cheat_loader.sv
`timescale 1ns/1ps

module cheat_loader (
	input  logic                 clk_sys,
	input  logic                 reset,
	dl_if.sink                   dl,
	output sms_pkg::cheat_code_t cheat_code,
	output logic                 cheat_strobe
);
	import sms_pkg::*;

	cheat_code_t hold;       // Record being assembled
	cheat_code_t hold_next;
	logic        code_wr;
	logic        last_wr;    // Byte 15 closes the record
	logic [3:0]  offset;
	logic [6:0]  bit_pos;

	assign code_wr = dl.wr & dl.code_sel;
	assign offset  = dl.addr[3:0];
	assign last_wr = code_wr && (offset == 4'hF);

	// Flags sit in the top word, so the word number counts down.
	// Within a word bytes go in LSB first.
	assign bit_pos = {~offset[3:2], offset[1:0], 3'b000};

	always_comb begin
		hold_next = hold;
		hold_next[bit_pos +: 8] = dl.dout;
	end

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			hold <= hold_next;
		end
		if (last_wr) begin
			cheat_code <= hold_next;  // Include the final byte
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_strobe <= 1'b0;
		end else begin
			cheat_strobe <= last_wr;
		end
	end

	// One strobe per record
	single_strobe: assert property (
		@(posedge clk_sys) disable iff (reset) cheat_strobe |=> !cheat_strobe
	) else $error("cheat_loader: cheat_strobe held for two cycles");

endmodule

// File: sms_glue_top.sv
`timescale 1ns/1ps

module sms_glue_top (
	input  logic                 clk_sys,
	input  logic                 reset,

	// Host download bus
	input  logic                 ioctl_download,
	input  logic                 ioctl_wr,
	input  sms_pkg::ioctl_addr_t ioctl_addr,
	input  sms_pkg::byte_t       ioctl_dout,
	input  sms_pkg::byte_t       ioctl_index,
	output logic                 ioctl_wait,

	// External ROM memory, write data is ioctl_dout
	output logic                 rom_req,
	input  logic                 rom_ack,
	output sms_pkg::rom_waddr_t  rom_waddr,
	input  sms_pkg::rom_addr_t   core_rom_addr,
	output sms_pkg::rom_addr_t   rom_raddr,
	output logic                 gg_mode,

	output sms_pkg::cheat_code_t cheat_code,
	output logic                 cheat_strobe,

	// Core clock enables
	output logic                 ce_cpu,
	output logic                 ce_vdp,
	output logic                 ce_pix,
	output logic                 ce_sp
);

	// ==============================
	// Download bus
	// ==============================
	dl_if dl (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	assign dl.download = ioctl_download;
	assign dl.wr       = ioctl_wr;
	assign dl.addr     = ioctl_addr;
	assign dl.dout     = ioctl_dout;
	assign dl.index    = ioctl_index;

	// ==============================
	// Blocks
	// ==============================
	ce_gen u_ce_gen (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_cpu  (ce_cpu),
		.ce_vdp  (ce_vdp),
		.ce_pix  (ce_pix),
		.ce_sp   (ce_sp)
	);

	cart_loader u_cart_loader (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl         (dl.sink),
		.rom_ack    (rom_ack),
		.rom_req    (rom_req),
		.rom_waddr  (rom_waddr),
		.ioctl_wait (ioctl_wait)
	);

	cart_mapper u_cart_mapper (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl            (dl.sink),
		.core_rom_addr (core_rom_addr),
		.rom_raddr     (rom_raddr),
		.gg_mode       (gg_mode)
	);

	cheat_loader u_cheat_loader (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl.sink),
		.cheat_code   (cheat_code),
		.cheat_strobe (cheat_strobe)
	);

endmodule

// File: tb_sms_glue.sv
`timescale 1ns/1ps

module tb_sms_glue;
	import sms_pkg::*;

	// Cheat record bytes, offset 0 in the low byte
	localparam logic [127:0] CHEAT_BYTES = 128'h8C41_0F27_00A5_5A3C_0000_1F80_0000_0001;
	localparam int N_STIM  = 3;
	localparam int N_PROBE = 4;

	typedef struct {
		logic      is_cheat;
		byte_t     index;
		int        length;  // Bytes in the download
		rom_addr_t mask;    // Image mask, or header mask with hdr set
		logic      hdr;
		logic      gg;
	} stim_t;

	logic        clk_sys;
	logic        reset;
	logic        ioctl_download;
	logic        ioctl_wr;
	ioctl_addr_t ioctl_addr;
	byte_t       ioctl_dout;
	byte_t       ioctl_index;
	logic        ioctl_wait;
	logic        rom_req;
	logic        rom_ack;
	rom_waddr_t  rom_waddr;
	rom_addr_t   core_rom_addr;
	rom_addr_t   rom_raddr;
	logic        gg_mode;
	cheat_code_t cheat_code;
	logic        cheat_strobe;
	logic        ce_cpu;
	logic        ce_vdp;
	logic        ce_pix;
	logic        ce_sp;

	stim_t     stim [N_STIM];
	rom_addr_t probe [N_PROBE];
	int        mem_pos;       // Bytes accepted by the memory model
	int        strobe_count;
	logic      cheat_phase;

	sms_glue_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ==============================
	// Helpers
	// ==============================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic fail_run();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		if (actual !== expected) begin
			$display("Error at time %0t: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected);
			fail_run();
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	// ==============================
	// Test steps
	// ==============================
	task automatic check_clock_enables();
		int c;  // Sequencer count behind the enables
		int k;
		c = 0;
		for (k = 0; k < 60; k++) begin
			next_cycle();
			check("ce_vdp", 128'(ce_vdp), 128'((c + 1) % 5 == 0));
			check("ce_pix", 128'(ce_pix), 128'((c + 1) % 10 == 0));
			check("ce_cpu", 128'(ce_cpu), 128'(c == 9 || c == 24));
			check("ce_sp", 128'(ce_sp), 128'(c % 2));
			c = (c + 1) % 30;
		end
	endtask

	task automatic load_cart(input stim_t s);
		int   i;
		logic req_before;
		ioctl_index    = s.index;
		ioctl_download = 1'b1;
		next_cycle();
		next_cycle();
		for (i = 0; i < s.length; i++) begin
			req_before = rom_req;
			ioctl_addr = ioctl_addr_t'(i);
			ioctl_dout = byte_t'(i);
			ioctl_wr   = 1'b1;
			next_cycle();
			ioctl_wr = 1'b0;
			check("rom_req", 128'(rom_req), 128'(!req_before));
			check("ioctl_wait", 128'(ioctl_wait), 128'(1'b1));
			while (ioctl_wait) begin
				next_cycle();
			end
		end
		check("memory writes", 128'(mem_pos), 128'(s.length));
		ioctl_addr     = ioctl_addr_t'(s.length);  // Image size at the end
		ioctl_download = 1'b0;
		next_cycle();
		next_cycle();
		check("gg_mode", 128'(gg_mode), 128'(s.gg));
	endtask

	task automatic probe_reads(input stim_t s);
		int        p;
		rom_addr_t expected;
		for (p = 0; p < N_PROBE; p++) begin
			core_rom_addr = probe[p];
			next_cycle();
			if (s.hdr) begin
				expected = (probe[p] + 22'd512) & s.mask;  // Skip copier header
			end else begin
				expected = probe[p] & s.mask;
			end
			check("rom_raddr", 128'(rom_raddr), 128'(expected));
		end
	endtask

	task automatic load_cheat(input stim_t s);
		int          i;
		cheat_code_t expected;
		cheat_phase    = 1'b1;
		ioctl_index    = s.index;
		ioctl_download = 1'b1;
		next_cycle();
		for (i = 0; i < s.length; i++) begin
			ioctl_addr = ioctl_addr_t'(i);
			ioctl_dout = CHEAT_BYTES[8*i +: 8];
			ioctl_wr   = 1'b1;
			next_cycle();
			ioctl_wr = 1'b0;
			check("cheat_strobe", 128'(cheat_strobe), 128'(i == 15));
			next_cycle();
			check("cheat_strobe", 128'(cheat_strobe), 128'(1'b0));
		end
		ioctl_download = 1'b0;
		next_cycle();
		next_cycle();
		// Each field LSB first, flags on top
		expected = {CHEAT_BYTES[31:0], CHEAT_BYTES[63:32],
			CHEAT_BYTES[95:64], CHEAT_BYTES[127:96]};
		check("cheat_code", cheat_code, expected);
		check("cheat_strobe count", 128'(strobe_count), 128'(1));
		cheat_phase = 1'b0;
	endtask

	// ==============================
	// External memory model
	// ==============================
	initial begin : memory_model
		logic [31:0] rng;
		logic        req_seen;
		logic        pending;
		logic        ack_due;
		int          delay;
		rng      = 32'd38005;
		req_seen = 1'b0;
		pending  = 1'b0;
		ack_due  = 1'b0;
		delay    = 0;
		rom_ack  = 1'b0;
		mem_pos  = 0;
		forever begin
			next_cycle();
			if (ack_due) begin
				check("ioctl_wait", 128'(ioctl_wait), 128'(1'b0));  // Released after ack
				check("rom_waddr", 128'(rom_waddr), 128'(mem_pos));
				ack_due = 1'b0;
			end
			if (!ioctl_download) begin
				mem_pos = 0;
			end
			if (rom_req !== req_seen) begin
				req_seen = rom_req;
				if (cheat_phase) begin
					$display("Memory write request seen during the cheat download");
					fail_run();
				end else begin
					check("rom_waddr", 128'(rom_waddr), 128'(mem_pos));
					check("rom write data", 128'(ioctl_dout), 128'(mem_pos % 256));
					check("ioctl_wait", 128'(ioctl_wait), 128'(1'b1));
					rng     = xorshift32(rng);
					delay   = 1 + int'(rng % 32'd6);
					pending = 1'b1;
				end
			end else if (pending) begin
				check("ioctl_wait", 128'(ioctl_wait), 128'(1'b1));
				delay--;
				if (delay == 0) begin
					rom_ack = req_seen;
					pending = 1'b0;
					ack_due = 1'b1;
					mem_pos++;
				end
			end
		end
	end

	initial begin : strobe_monitor
		strobe_count = 0;
		forever begin
			next_cycle();
			if (cheat_strobe) begin
				strobe_count++;
			end
		end
	end

	initial begin : watchdog
		int total;
		int e;
		#1;
		total = 0;
		for (e = 0; e < N_STIM; e++) begin
			total += stim[e].length;
		end
		repeat (total * 8 + 500) @(posedge clk_sys);
		$display("Timeout: the tests did not finish within the time limit");
		fail_run();
	end

	// ==============================
	// Main sequence
	// ==============================
	initial begin : main
		int e;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_index    = '0;
		core_rom_addr  = '0;
		cheat_phase    = 1'b0;

		stim[0] = '{1'b0, IDX_SMS, 2048, 22'h0007FF, 1'b0, 1'b0};
		stim[1] = '{1'b0, IDX_GG, 1536, 22'h0003FF, 1'b1, 1'b1};  // 512-byte header
		stim[2] = '{1'b1, IDX_CODE, 16, 22'h000000, 1'b0, 1'b1};
		probe[0] = 22'h000000;
		probe[1] = 22'h0001A5;
		probe[2] = 22'h2ABCD3;
		probe[3] = 22'h3FFFFF;

		for (e = 0; e < 5; e++) begin
			next_cycle();
		end
		reset = 1'b0;

		check_clock_enables();
		for (e = 0; e < N_STIM; e++) begin
			if (stim[e].is_cheat) begin
				load_cheat(stim[e]);
			end else begin
				load_cart(stim[e]);
				probe_reads(stim[e]);
			end
		end

		$display("Done: no errors");
		$finish;
	end

endmodule

// File: filelist.f
sms_pkg.sv
dl_if.sv
ce_gen.sv
cart_loader.sv
cart_mapper.sv
cheat_loader.sv
sms_glue_top.sv
tb_sms_glue.sv

// File: run_sim.sh
#!/bin/sh
# Build and run tb_sms_glue with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_sms_glue \
	-f filelist.f \
	-o tb_sms_glue
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_sms_glue > "$LOG" 2>&1
run_status=$?
cat "$LOG"

# Verdict comes from the log
if grep -q "Done: errors found" "$LOG"; then
	echo "Simulation FAILED"
	exit 1
fi
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

echo "Simulation PASSED"
exit 0
